//--- design/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Program counter value after reset, pointing into boot flash.
`define FETCH_RESET_PC 32'h3000_0000

// Cacheable SDRAM window. The upper bound is exclusive.
`define FETCH_SDRAM_BASE 32'hA000_0000
`define FETCH_SDRAM_LIMIT 32'hA200_0000

// Instruction cache geometry. The line count must be a power of two.
`define FETCH_CACHE_LINES 16

// One 16-byte line is four 32-bit words.
`define FETCH_BURST_BEATS 4

`endif

//--- design/fetch_pkg.sv
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

	localparam int INDEX_BITS = $clog2(`FETCH_CACHE_LINES);
	localparam int TAG_BITS = 32 - INDEX_BITS - 4;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [INDEX_BITS-1:0] line_index_t;
	typedef logic [TAG_BITS-1:0] line_tag_t;
	typedef logic [1:0] beat_t;
	typedef logic [31:0] stat_t;

	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_LOOKUP,
		FETCH_SINGLE,
		FETCH_BURST,
		FETCH_FILL,
		FETCH_DELIVER
	} fetch_state_t;

	typedef enum logic {
		CACHE_READY,
		CACHE_RESPOND
	} cache_state_t;

endpackage

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module icache (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   lookup_valid,
	input  wire fetch_pkg::addr_t lookup_addr,
	output logic                  lookup_ready,
	output logic                  resp_valid,
	output logic                  resp_hit,
	output fetch_pkg::word_t      resp_data,
	input  wire                   fill_valid,
	input  wire fetch_pkg::addr_t fill_addr,
	input  wire fetch_pkg::word_t fill_data,
	output logic                  fill_ready
);

	localparam int LINES = `FETCH_CACHE_LINES;
	localparam int BEATS = `FETCH_BURST_BEATS;
	localparam int IDX_LO = 4;
	localparam int IDX_HI = IDX_LO + fetch_pkg::INDEX_BITS - 1;
	localparam fetch_pkg::beat_t LAST_OFFSET = fetch_pkg::beat_t'(BEATS - 1);

	fetch_pkg::cache_state_t state;
	fetch_pkg::addr_t req_addr;

	fetch_pkg::line_tag_t tag_mem [LINES];
	fetch_pkg::word_t data_mem [LINES][BEATS];
	logic [LINES-1:0] line_valid;

	fetch_pkg::line_index_t req_index;
	fetch_pkg::line_tag_t req_tag;
	fetch_pkg::beat_t req_offset;
	fetch_pkg::line_index_t fill_index;
	fetch_pkg::line_tag_t fill_tag;
	fetch_pkg::beat_t fill_offset;

	logic lookup_fire;
	logic fill_fire;

	assign req_index = req_addr[IDX_HI:IDX_LO];
	assign req_tag = req_addr[31:IDX_HI+1];
	assign req_offset = req_addr[3:2];

	assign fill_index = fill_addr[IDX_HI:IDX_LO];
	assign fill_tag = fill_addr[31:IDX_HI+1];
	assign fill_offset = fill_addr[3:2];

	// Writes never stall, so a line fill takes exactly one cycle per word.
	assign fill_ready = 1'b1;
	assign lookup_ready = (state == fetch_pkg::CACHE_READY);

	assign lookup_fire = lookup_valid && lookup_ready;
	assign fill_fire = fill_valid && fill_ready;

	// The tag compare happens in the cycle after the lookup, on the held address.
	assign resp_valid = (state == fetch_pkg::CACHE_RESPOND);
	assign resp_hit = line_valid[req_index] && (tag_mem[req_index] == req_tag);
	assign resp_data = data_mem[req_index][req_offset];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::CACHE_READY;
		end else begin
			unique case (state)
				fetch_pkg::CACHE_READY: begin
					if (lookup_fire) begin
						state <= fetch_pkg::CACHE_RESPOND;
					end
				end
				fetch_pkg::CACHE_RESPOND: begin
					state <= fetch_pkg::CACHE_READY;
				end
				default: begin
					state <= fetch_pkg::CACHE_READY;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_fire) begin
			req_addr <= lookup_addr;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_fire) begin
			data_mem[fill_index][fill_offset] <= fill_data;
			if (fill_offset == LAST_OFFSET) begin
				tag_mem[fill_index] <= fill_tag;
			end
		end
	end

	// A line is invalid while it is being refilled and turns valid with its last word.
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (fill_fire) begin
			if (fill_offset == '0) begin
				line_valid[fill_index] <= 1'b0;
			end else if (fill_offset == LAST_OFFSET) begin
				line_valid[fill_index] <= 1'b1;
			end
		end
	end

	// The fetch controller must never overlap a lookup with a refill write.
	no_lookup_during_fill: assert property (
		@(posedge clock) disable iff (reset)
		!(lookup_fire && fill_fire)
	);

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module fetch_unit #(
	parameter fetch_pkg::addr_t RESET_PC = `FETCH_RESET_PC
) (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   wb_valid,
	input  wire fetch_pkg::addr_t jump_addr,
	output fetch_pkg::addr_t      pc,
	output fetch_pkg::word_t      inst,
	output logic                  idu_valid,
	input  wire                   idu_ready,
	output fetch_pkg::addr_t      mem_araddr,
	output logic [3:0]            mem_arlen,
	output logic [1:0]            mem_arburst,
	output logic                  mem_arvalid,
	input  wire                   mem_arready,
	input  wire fetch_pkg::word_t mem_rdata,
	input  wire [1:0]             mem_rresp,
	input  wire                   mem_rlast,
	input  wire                   mem_rvalid,
	output logic                  mem_rready,
	output logic                  lookup_valid,
	output fetch_pkg::addr_t      lookup_addr,
	input  wire                   lookup_ready,
	input  wire                   resp_valid,
	input  wire                   resp_hit,
	input  wire fetch_pkg::word_t resp_data,
	output logic                  fill_valid,
	output fetch_pkg::addr_t      fill_addr,
	output fetch_pkg::word_t      fill_data,
	input  wire                   fill_ready,
	output logic                  stat_hit,
	output logic                  stat_miss,
	output logic                  stat_busy
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::beat_t beat;
	fetch_pkg::word_t beat_data;
	logic ar_sent;
	logic lookup_sent;
	logic beat_last;
	logic jump_cacheable;
	logic reading;

	assign jump_cacheable = (jump_addr >= `FETCH_SDRAM_BASE) && (jump_addr < `FETCH_SDRAM_LIMIT);
	assign reading = (state == fetch_pkg::FETCH_SINGLE) || (state == fetch_pkg::FETCH_BURST);

	// A refill bursts the whole 16-byte line starting at its first word.
	assign mem_arvalid = reading && !ar_sent;
	assign mem_rready = reading && ar_sent;
	assign mem_araddr = (state == fetch_pkg::FETCH_BURST) ? {pc[31:4], 4'b0000} : pc;
	assign mem_arlen = (state == fetch_pkg::FETCH_BURST) ? 4'(`FETCH_BURST_BEATS - 1) : 4'd0;
	assign mem_arburst = (state == fetch_pkg::FETCH_BURST) ? 2'b01 : 2'b00;

	assign lookup_valid = (state == fetch_pkg::FETCH_LOOKUP) && !lookup_sent;
	assign lookup_addr = pc;

	assign fill_valid = (state == fetch_pkg::FETCH_FILL);
	assign fill_addr = {pc[31:4], beat, 2'b00};
	assign fill_data = beat_data;

	assign idu_valid = (state == fetch_pkg::FETCH_DELIVER);

	assign stat_hit = (state == fetch_pkg::FETCH_LOOKUP) && resp_valid && resp_hit;
	assign stat_miss = (state == fetch_pkg::FETCH_LOOKUP) && resp_valid && !resp_hit;
	assign stat_busy = (state != fetch_pkg::FETCH_IDLE) && (state != fetch_pkg::FETCH_DELIVER);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::FETCH_IDLE;
			pc <= RESET_PC;
			ar_sent <= 1'b0;
			lookup_sent <= 1'b0;
			beat <= '0;
		end else begin
			if (mem_arvalid && mem_arready) begin
				ar_sent <= 1'b1;
			end
			unique case (state)
				fetch_pkg::FETCH_IDLE: begin
					if (wb_valid) begin
						pc <= jump_addr;
						ar_sent <= 1'b0;
						lookup_sent <= 1'b0;
						state <= jump_cacheable ? fetch_pkg::FETCH_LOOKUP : fetch_pkg::FETCH_SINGLE;
					end
				end
				fetch_pkg::FETCH_LOOKUP: begin
					if (lookup_valid && lookup_ready) begin
						lookup_sent <= 1'b1;
					end
					if (resp_valid) begin
						beat <= '0;
						state <= resp_hit ? fetch_pkg::FETCH_DELIVER : fetch_pkg::FETCH_BURST;
					end
				end
				fetch_pkg::FETCH_SINGLE: begin
					if (mem_rvalid && mem_rready) begin
						state <= fetch_pkg::FETCH_DELIVER;
					end
				end
				fetch_pkg::FETCH_BURST: begin
					if (mem_rvalid && mem_rready) begin
						state <= fetch_pkg::FETCH_FILL;
					end
				end
				fetch_pkg::FETCH_FILL: begin
					if (fill_ready) begin
						beat <= beat + 1'b1;
						state <= beat_last ? fetch_pkg::FETCH_DELIVER : fetch_pkg::FETCH_BURST;
					end
				end
				fetch_pkg::FETCH_DELIVER: begin
					if (idu_ready) begin
						state <= fetch_pkg::FETCH_IDLE;
					end
				end
				default: begin
					state <= fetch_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

	// The wanted word is kept as soon as its beat shows up, even mid-burst.
	always_ff @(posedge clock) begin
		if (state == fetch_pkg::FETCH_LOOKUP && resp_valid && resp_hit) begin
			inst <= resp_data;
		end else if (mem_rvalid && mem_rready) begin
			if (state == fetch_pkg::FETCH_SINGLE || beat == pc[3:2]) begin
				inst <= mem_rdata;
			end
		end
		if (state == fetch_pkg::FETCH_BURST && mem_rvalid && mem_rready) begin
			beat_data <= mem_rdata;
			beat_last <= mem_rlast;
		end
	end

	arvalid_held: assert property (
		@(posedge clock) disable iff (reset)
		(mem_arvalid && !mem_arready) |=> (mem_arvalid && $stable(mem_araddr))
	);

	idu_valid_held: assert property (
		@(posedge clock) disable iff (reset)
		(idu_valid && !idu_ready) |=> (idu_valid && $stable(inst) && $stable(pc))
	);

	// Error responses are not handled, so memory must always answer OKAY.
	read_resp_okay: assert property (
		@(posedge clock) disable iff (reset)
		(mem_rvalid && mem_rready) |-> (mem_rresp == 2'b00)
	);

endmodule

`default_nettype wire

//--- design/fetch_counters.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_counters (
	input  wire              clock,
	input  wire              reset,
	input  wire              stat_hit,
	input  wire              stat_miss,
	input  wire              stat_busy,
	output fetch_pkg::stat_t hit_count,
	output fetch_pkg::stat_t miss_count,
	output fetch_pkg::stat_t busy_cycles
);

	// Counters stick at their maximum instead of wrapping back to zero.
	function automatic fetch_pkg::stat_t saturating_step(
		input fetch_pkg::stat_t count,
		input logic event_seen
	);
		if (event_seen && (count != '1)) begin
			return count + 1'b1;
		end
		return count;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			hit_count <= '0;
			miss_count <= '0;
			busy_cycles <= '0;
		end else begin
			hit_count <= saturating_step(hit_count, stat_hit);
			miss_count <= saturating_step(miss_count, stat_miss);
			busy_cycles <= saturating_step(busy_cycles, stat_busy);
		end
	end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module fetch_top (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   wb_valid,
	input  wire fetch_pkg::addr_t jump_addr,
	output fetch_pkg::addr_t      pc,
	output fetch_pkg::word_t      inst,
	output logic                  idu_valid,
	input  wire                   idu_ready,
	output fetch_pkg::addr_t      mem_araddr,
	output logic [3:0]            mem_arlen,
	output logic [1:0]            mem_arburst,
	output logic                  mem_arvalid,
	input  wire                   mem_arready,
	input  wire fetch_pkg::word_t mem_rdata,
	input  wire [1:0]             mem_rresp,
	input  wire                   mem_rlast,
	input  wire                   mem_rvalid,
	output logic                  mem_rready,
	output fetch_pkg::stat_t      hit_count,
	output fetch_pkg::stat_t      miss_count,
	output fetch_pkg::stat_t      busy_cycles
);

	logic lookup_valid;
	fetch_pkg::addr_t lookup_addr;
	logic lookup_ready;
	logic resp_valid;
	logic resp_hit;
	fetch_pkg::word_t resp_data;
	logic fill_valid;
	fetch_pkg::addr_t fill_addr;
	fetch_pkg::word_t fill_data;
	logic fill_ready;
	logic stat_hit;
	logic stat_miss;
	logic stat_busy;

	fetch_unit #(
		.RESET_PC(`FETCH_RESET_PC)
	) u_fetch_unit (
		.clock(clock),
		.reset(reset),
		.wb_valid(wb_valid),
		.jump_addr(jump_addr),
		.pc(pc),
		.inst(inst),
		.idu_valid(idu_valid),
		.idu_ready(idu_ready),
		.mem_araddr(mem_araddr),
		.mem_arlen(mem_arlen),
		.mem_arburst(mem_arburst),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_rdata(mem_rdata),
		.mem_rresp(mem_rresp),
		.mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready),
		.lookup_valid(lookup_valid),
		.lookup_addr(lookup_addr),
		.lookup_ready(lookup_ready),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_data(resp_data),
		.fill_valid(fill_valid),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.fill_ready(fill_ready),
		.stat_hit(stat_hit),
		.stat_miss(stat_miss),
		.stat_busy(stat_busy)
	);

	icache u_icache (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_addr(lookup_addr),
		.lookup_ready(lookup_ready),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_data(resp_data),
		.fill_valid(fill_valid),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.fill_ready(fill_ready)
	);

	fetch_counters u_fetch_counters (
		.clock(clock),
		.reset(reset),
		.stat_hit(stat_hit),
		.stat_miss(stat_miss),
		.stat_busy(stat_busy),
		.hit_count(hit_count),
		.miss_count(miss_count),
		.busy_cycles(busy_cycles)
	);

endmodule

`default_nettype wire

//--- sim/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model #(
	parameter logic [31:0] SEED = 32'd64111
) (
	input  wire         clock,
	input  wire         reset,
	input  wire  [31:0] mem_araddr,
	input  wire  [3:0]  mem_arlen,
	input  wire  [1:0]  mem_arburst,
	input  wire         mem_arvalid,
	output logic        mem_arready,
	output logic [31:0] mem_rdata,
	output logic [1:0]  mem_rresp,
	output logic        mem_rlast,
	output logic        mem_rvalid,
	input  wire         mem_rready
);

	logic [31:0] random_state = SEED;
	logic [31:0] random_next;
	logic arready_q = 1'b0;
	logic rvalid_q = 1'b0;
	logic rlast_q = 1'b0;
	logic [31:0] rdata_q = '0;
	logic busy = 1'b0;
	logic incrementing = 1'b0;
	logic [31:0] beat_addr = '0;
	logic [3:0] beats_left = '0;
	logic [1:0] delay = '0;

	function automatic logic [31:0] lcg_next(input logic [31:0] value);
		return value * 32'd1103515245 + 32'd12345;
	endfunction

	// Every word holds its own address scrambled with a fixed pattern.
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h5A5A_5A5A;
	endfunction

	assign random_next = lcg_next(random_state);
	assign mem_arready = arready_q;
	assign mem_rvalid = rvalid_q;
	assign mem_rlast = rlast_q;
	assign mem_rdata = rdata_q;
	assign mem_rresp = 2'b00;

	always @(posedge clock) begin
		random_state <= random_next;
		if (reset) begin
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
			rlast_q <= 1'b0;
			busy <= 1'b0;
			delay <= '0;
		end else if (!busy) begin
			if (mem_arvalid && arready_q) begin
				busy <= 1'b1;
				arready_q <= 1'b0;
				beat_addr <= mem_araddr;
				beats_left <= mem_arlen;
				incrementing <= (mem_arburst == 2'b01);
				delay <= random_next[17:16];
			end else begin
				arready_q <= random_next[20];
			end
		end else if (rvalid_q) begin
			if (mem_rready) begin
				rvalid_q <= 1'b0;
				if (rlast_q) begin
					busy <= 1'b0;
				end else begin
					beats_left <= beats_left - 1'b1;
					delay <= random_next[17:16];
					if (incrementing) begin
						beat_addr <= beat_addr + 32'd4;
					end
				end
			end
		end else if (delay != '0) begin
			delay <= delay - 1'b1;
		end else begin
			rvalid_q <= 1'b1;
			rdata_q <= word_at(beat_addr);
			rlast_q <= (beats_left == '0);
		end
	end

endmodule

`default_nettype wire

//--- sim/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb;

	localparam int MAX_ROWS = 16;
	localparam int CYCLES_PER_ROW = 400;

	logic clock;
	logic reset;
	logic wb_valid;
	fetch_pkg::addr_t jump_addr;
	logic idu_ready;
	fetch_pkg::addr_t pc;
	fetch_pkg::word_t inst;
	logic idu_valid;
	fetch_pkg::addr_t mem_araddr;
	logic [3:0] mem_arlen;
	logic [1:0] mem_arburst;
	logic mem_arvalid;
	logic mem_arready;
	fetch_pkg::word_t mem_rdata;
	logic [1:0] mem_rresp;
	logic mem_rlast;
	logic mem_rvalid;
	logic mem_rready;
	fetch_pkg::stat_t hit_count;
	fetch_pkg::stat_t miss_count;
	fetch_pkg::stat_t busy_cycles;

	string row_name [MAX_ROWS];
	fetch_pkg::addr_t row_addr [MAX_ROWS];
	logic row_hit [MAX_ROWS];
	int row_stall [MAX_ROWS];
	int row_count = 0;

	int cycle_count = 0;
	int ar_count = 0;
	fetch_pkg::addr_t last_araddr = '0;
	logic [3:0] last_arlen = '0;
	logic [1:0] last_arburst = '0;
	int expected_hits = 0;
	int expected_misses = 0;
	int expected_ar = 0;

	fetch_top uut (.*);

	mem_model memory (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Read address transfers, sampled half a cycle before the edge that takes them.
	always @(negedge clock) begin
		if (mem_arvalid && mem_arready) begin
			ar_count <= ar_count + 1;
			last_araddr <= mem_araddr;
			last_arlen <= mem_arlen;
			last_arburst <= mem_arburst;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLES_PER_ROW * row_count + 20) begin
			$display("Timeout after %0d cycles waiting for the fetch unit", cycle_count);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	function automatic fetch_pkg::word_t expected_word(input fetch_pkg::addr_t addr);
		return {addr[31:2], 2'b00} ^ 32'h5A5A_5A5A;
	endfunction

	function automatic logic in_sdram(input fetch_pkg::addr_t addr);
		return (addr >= `FETCH_SDRAM_BASE) && (addr < `FETCH_SDRAM_LIMIT);
	endfunction

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", what, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic add_row(input string name, input fetch_pkg::addr_t addr, input logic hit,
		input int stall);
		row_name[row_count] = name;
		row_addr[row_count] = addr;
		row_hit[row_count] = hit;
		row_stall[row_count] = stall;
		row_count++;
	endtask

	task automatic run_row(input int i);
		int waited;
		fetch_pkg::word_t held_inst;
		fetch_pkg::addr_t held_pc;
		fetch_pkg::stat_t busy_before;
		busy_before = busy_cycles;
		@(posedge clock);
		jump_addr <= row_addr[i];
		wb_valid <= 1'b1;
		@(posedge clock);
		wb_valid <= 1'b0;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!idu_valid);
		compare({row_name[i], " inst"}, expected_word(row_addr[i]), inst);
		compare({row_name[i], " pc"}, row_addr[i], pc);
		held_inst = inst;
		held_pc = pc;
		repeat (row_stall[i]) begin
			@(negedge clock);
			compare({row_name[i], " valid held"}, 32'd1, 32'(idu_valid));
			compare({row_name[i], " inst held"}, held_inst, inst);
			compare({row_name[i], " pc held"}, held_pc, pc);
		end
		@(posedge clock);
		idu_ready <= 1'b1;
		@(posedge clock);
		idu_ready <= 1'b0;
		@(negedge clock);
		compare({row_name[i], " valid dropped"}, 32'd0, 32'(idu_valid));
		if (!in_sdram(row_addr[i])) begin
			expected_ar++;
			compare({row_name[i], " single addr"}, row_addr[i], last_araddr);
			compare({row_name[i], " single len"}, 32'd0, 32'(last_arlen));
		end else if (row_hit[i]) begin
			expected_hits++;
			// Lookup, respond and deliver.
			compare({row_name[i], " hit latency"}, 32'd3, waited);
		end else begin
			expected_misses++;
			expected_ar++;
			compare({row_name[i], " burst addr"}, {row_addr[i][31:4], 4'h0}, last_araddr);
			compare({row_name[i], " burst len"}, 32'd3, 32'(last_arlen));
			compare({row_name[i], " burst type"}, 32'd1, 32'(last_arburst));
		end
		compare({row_name[i], " hit count"}, expected_hits, hit_count);
		compare({row_name[i], " miss count"}, expected_misses, miss_count);
		compare({row_name[i], " read addr count"}, expected_ar, ar_count);
		compare({row_name[i], " busy grew"}, 32'd1, 32'(busy_cycles > busy_before));
	endtask

	initial begin
		reset = 1'b1;
		wb_valid = 1'b0;
		jump_addr = '0;
		idu_ready = 1'b0;

		// Index is address bits 7:4 and the tag is bits 31:8.
		add_row("uncached_boot", 32'h3000_0104, 1'b0, 0);
		add_row("miss_word0", 32'hA000_0040, 1'b0, 0);
		add_row("miss_word1", 32'hA000_0054, 1'b0, 1);
		add_row("miss_word2", 32'hA000_0068, 1'b0, 0);
		add_row("miss_word3", 32'hA000_007C, 1'b0, 0);
		add_row("hit_line_a", 32'hA000_0048, 1'b1, 2);
		add_row("hit_line_b", 32'hA000_0050, 1'b1, 0);
		add_row("hit_stalled", 32'hA000_0074, 1'b1, 5);
		add_row("uncached_stalled", 32'h1000_0008, 1'b0, 3);
		add_row("conflict_miss", 32'hA000_1040, 1'b0, 0);
		add_row("evicted_refetch", 32'hA000_0044, 1'b0, 1);
		add_row("hit_refilled", 32'hA000_004C, 1'b1, 0);
		add_row("window_top", 32'hA1FF_FFFC, 1'b0, 2);
		add_row("above_window", 32'hA200_0000, 1'b0, 0);

		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		compare("reset pc", `FETCH_RESET_PC, pc);
		compare("reset idu_valid", 32'd0, 32'(idu_valid));
		compare("reset mem_arvalid", 32'd0, 32'(mem_arvalid));
		compare("reset mem_rready", 32'd0, 32'(mem_rready));
		compare("reset hit count", 32'd0, hit_count);
		compare("reset miss count", 32'd0, miss_count);
		compare("reset busy cycles", 32'd0, busy_cycles);

		for (int i = 0; i < row_count; i++) begin
			run_row(i);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/fetch_pkg.sv
design/icache.sv
design/fetch_unit.sv
design/fetch_counters.sv
design/fetch_top.sv
sim/mem_model.sv
sim/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert --timescale 1ns/1ns
PASS_TEXT ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
